// File: common/wb_pkg.sv
// Wishbone bus widths, debug region decode constants and debug register indices
// Byte-lane merge helper shared by the register banks
package wb_pkg;

    // Bus widths
    localparam int unsigned WB_DW = 32;
    localparam int unsigned WB_AW = 32;
    localparam int unsigned WB_SW = 4;

    // Address bits compared against the debug tag
    localparam int unsigned DEBUG_TAG_HI = 19;
    localparam int unsigned DEBUG_TAG_LO = 3;
    // Top two words of the user area, all ones over the tag field
    localparam logic [DEBUG_TAG_HI-DEBUG_TAG_LO:0] DEBUG_TAG = '1;

    // Word offset inside a region
    localparam int unsigned WORD_ADR_HI = 3;
    localparam int unsigned WORD_ADR_LO = 2;

    // Debug register indices, picked by address bit 2
    localparam int unsigned DEBUG_REG_0 = 0;
    localparam int unsigned DEBUG_REG_1 = 1;

    // Replace only the byte lanes flagged in sel
    function automatic logic [WB_DW-1:0] wb_byte_merge(
        input logic [WB_DW-1:0] old_word,
        input logic [WB_DW-1:0] new_word,
        input logic [WB_SW-1:0] sel
    );
        logic [WB_DW-1:0] merged;
        merged = old_word;
        for (int b = 0; b < WB_SW; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// File: common/timer_pkg.sv
// Interval timer register offsets, control bit positions and mode enum
package timer_pkg;

    // Word offsets, taken from address bits 3:2
    localparam logic [1:0] TMR_CTRL   = 2'd0;
    localparam logic [1:0] TMR_LOAD   = 2'd1;
    localparam logic [1:0] TMR_COUNT  = 2'd2;
    localparam logic [1:0] TMR_STATUS = 2'd3;

    // CTRL register bits
    localparam int unsigned CTRL_EN_BIT     = 0;
    localparam int unsigned CTRL_MODE_BIT   = 1;
    localparam int unsigned CTRL_IRQ_EN_BIT = 2;
    // Implemented CTRL width, upper bits read as zero
    localparam int unsigned CTRL_W = CTRL_IRQ_EN_BIT + 1;

    // Counter behaviour on reaching zero
    typedef enum logic {
        MODE_ONESHOT  = 1'b0,
        MODE_PERIODIC = 1'b1
    } timer_mode_e;

endpackage

// File: common/reg_bus_if.sv
// Single-cycle register access bus between a slave FSM and a register bank
interface reg_bus_if import wb_pkg::*; ();

    // One-cycle access strobe
    logic             req;
    logic             we;
    logic [WB_SW-1:0] sel;
    // Word index inside the region
    logic [1:0]       word_adr;
    logic [WB_DW-1:0] wdata;
    // Registered by the bank on a read, held until the next req
    logic [WB_DW-1:0] rdata;

    modport master (
        output req,
        output we,
        output sel,
        output word_adr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  req,
        input  we,
        input  sel,
        input  word_adr,
        input  wdata,
        output rdata
    );

endinterface

// File: source/wb_decode.sv
// Region decode of the Wishbone cycle and response mux of ack and read data
module wb_decode import wb_pkg::*; (
    input  logic             wbs_cyc_i,
    input  logic [WB_AW-1:0] wbs_adr_i,
    input  logic             ack_user_i,
    input  logic             ack_debug_i,
    input  logic [WB_DW-1:0] dat_user_i,
    input  logic [WB_DW-1:0] dat_debug_i,
    output logic             cyc_user_o,
    output logic             cyc_debug_o,
    output logic             wbs_ack_o,
    output logic [WB_DW-1:0] wbs_dat_o
);

    // Single tag compare shared by cyc gating and response select
    logic hit_debug;

    assign hit_debug = (wbs_adr_i[DEBUG_TAG_HI:DEBUG_TAG_LO] == DEBUG_TAG);

    // Only the addressed region sees the cycle
    assign cyc_user_o  = wbs_cyc_i & ~hit_debug;
    assign cyc_debug_o = wbs_cyc_i & hit_debug;

    // Response comes from the same region that got cyc
    assign wbs_ack_o = hit_debug ? ack_debug_i : ack_user_i;
    assign wbs_dat_o = hit_debug ? dat_debug_i : dat_user_i;

endmodule

// File: source/wb_slave_fsm.sv
// Wishbone classic slave FSM that turns one bus cycle into one register access
module wb_slave_fsm import wb_pkg::*; (
    input  logic             wb_clk_i,
    input  logic             reset_i,
    input  logic             wbs_cyc_i,
    input  logic             wbs_stb_i,
    input  logic             wbs_we_i,
    input  logic [WB_SW-1:0] wbs_sel_i,
    input  logic [WB_AW-1:0] wbs_adr_i,
    input  logic [WB_DW-1:0] wbs_dat_i,
    output logic             wbs_ack_o,
    output logic [WB_DW-1:0] wbs_dat_o,
    reg_bus_if.master        bus
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        ACK,
        WAIT_END
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   cyc_stb;
    logic   start;

    assign cyc_stb = wbs_cyc_i & wbs_stb_i;
    // New cycle accepted only from IDLE
    assign start   = (state_q == IDLE) & cyc_stb;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (cyc_stb) begin
                    state_d = ACCESS;
                end
            end
            // Bank does its work on this edge
            ACCESS: state_d = ACK;
            ACK: state_d = WAIT_END;
            // Master must drop stb before the next access
            WAIT_END: begin
                if (!cyc_stb) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Latch the request fields when the cycle is accepted
    always_ff @(posedge wb_clk_i) begin
        if (start) begin
            bus.we       <= wbs_we_i;
            bus.sel      <= wbs_sel_i;
            bus.word_adr <= wbs_adr_i[WORD_ADR_HI:WORD_ADR_LO];
            bus.wdata    <= wbs_dat_i;
        end
    end

    // One-cycle strobe to the bank
    assign bus.req = (state_q == ACCESS);

    // Ack in the second cycle after stb was sampled
    assign wbs_ack_o = (state_q == ACK);
    // Read data only visible alongside ack
    assign wbs_dat_o = wbs_ack_o ? bus.rdata : '0;

endmodule

// File: source/debug_regs.sv
// Two byte-writable debug scratch registers on the register access bus
module debug_regs import wb_pkg::*; (
    input  logic      wb_clk_i,
    input  logic      reset_i,
    reg_bus_if.slave  bus
);

    logic [WB_DW-1:0] scratch_q [2];
    // Register index from address bit 2
    logic             idx;

    assign idx = bus.word_adr[0];

    // Byte-lane writes, untouched lanes keep their value
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            scratch_q[DEBUG_REG_0] <= '0;
            scratch_q[DEBUG_REG_1] <= '0;
        end else if (bus.req && bus.we) begin
            scratch_q[idx] <= wb_byte_merge(scratch_q[idx], bus.wdata, bus.sel);
        end
    end

    // Read data captured on the access edge and held until next req
    always_ff @(posedge wb_clk_i) begin
        if (bus.req && !bus.we) begin
            if (idx == DEBUG_REG_1[0]) begin
                bus.rdata <= scratch_q[DEBUG_REG_1];
            end else begin
                bus.rdata <= scratch_q[DEBUG_REG_0];
            end
        end
    end

endmodule

// File: timer/interval_timer.sv
// Prescaled down-counter with zero match, periodic reload and one-shot stop
module interval_timer import timer_pkg::*; #(
    parameter int unsigned PRESCALE_W = 4
) (
    input  logic        wb_clk_i,
    input  logic        reset_i,
    input  logic        enable_i,
    input  timer_mode_e mode_i,
    input  logic [31:0] load_i,
    input  logic        load_now_i,
    output logic [31:0] count_o,
    output logic        match_o,
    output logic        done_o
);

    logic [PRESCALE_W-1:0] presc_q;
    logic [31:0]           count_q;
    logic                  tick;
    logic                  at_one;

    // One tick every 2**PRESCALE_W clocks while running
    assign tick   = enable_i & (presc_q == '1);
    assign at_one = (count_q == 32'd1);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i || !enable_i) begin
            presc_q <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            count_q <= '0;
            match_o <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            if (load_now_i) begin
                count_q <= load_i;
            end else if (tick) begin
                if (count_q != '0) begin
                    count_q <= count_q - 1'b1;
                end else if (mode_i == MODE_PERIODIC) begin
                    // Tick after zero restarts the period
                    count_q <= load_i;
                end
            end
            // Pulses land with the count reaching zero
            match_o <= tick & at_one;
            done_o  <= tick & at_one & (mode_i == MODE_ONESHOT);
        end
    end

    assign count_o = count_q;

endmodule

// File: timer/timer_regs.sv
// Timer register bank with CTRL, LOAD, COUNT and STATUS
// Owns the interval timer and drives the user interrupt
module timer_regs import wb_pkg::*; import timer_pkg::*; #(
    parameter int unsigned PRESCALE_W = 4
) (
    input  logic     wb_clk_i,
    input  logic     reset_i,
    reg_bus_if.slave bus,
    output logic     user_irq_o
);

    logic [CTRL_W-1:0] ctrl_q;
    logic [WB_DW-1:0]  load_q;
    logic              status_q;
    logic              irq_q;

    logic              wr;
    logic              wr_ctrl;
    logic              wr_load;
    logic              wr_status;
    logic [WB_DW-1:0]  ctrl_next;
    logic [WB_DW-1:0]  load_next;
    logic              load_now;
    logic [WB_DW-1:0]  load_val;
    timer_mode_e       mode;
    logic [WB_DW-1:0]  count;
    logic              match;
    logic              done;

    // Write decode
    assign wr        = bus.req & bus.we;
    assign wr_ctrl   = wr & (bus.word_adr == TMR_CTRL);
    assign wr_load   = wr & (bus.word_adr == TMR_LOAD);
    assign wr_status = wr & (bus.word_adr == TMR_STATUS);

    assign ctrl_next = wb_byte_merge({{(WB_DW-CTRL_W){1'b0}}, ctrl_q}, bus.wdata, bus.sel);
    assign load_next = wb_byte_merge(load_q, bus.wdata, bus.sel);

    // Writing LOAD while stopped also presets the counter
    assign load_now = wr_load & ~ctrl_q[CTRL_EN_BIT];
    // Counter takes the new value on the same edge as load_q
    assign load_val = load_now ? load_next : load_q;

    assign mode = timer_mode_e'(ctrl_q[CTRL_MODE_BIT]);

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            ctrl_q <= '0;
            load_q <= '0;
        end else begin
            if (wr_ctrl) begin
                ctrl_q <= ctrl_next[CTRL_W-1:0];
            end else if (done) begin
                // One-shot expiry stops the timer
                ctrl_q[CTRL_EN_BIT] <= 1'b0;
            end
            if (wr_load) begin
                load_q <= load_next;
            end
        end
    end

    // Sticky match flag, write one to clear, set wins
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            status_q <= 1'b0;
            irq_q    <= 1'b0;
        end else begin
            if (match) begin
                status_q <= 1'b1;
            end else if (wr_status && bus.sel[0] && bus.wdata[0]) begin
                status_q <= 1'b0;
            end
            irq_q <= status_q & ctrl_q[CTRL_IRQ_EN_BIT];
        end
    end

    assign user_irq_o = irq_q;

    always_ff @(posedge wb_clk_i) begin
        if (bus.req && !bus.we) begin
            unique case (bus.word_adr)
                TMR_CTRL:   bus.rdata <= {{(WB_DW-CTRL_W){1'b0}}, ctrl_q};
                TMR_LOAD:   bus.rdata <= load_q;
                TMR_COUNT:  bus.rdata <= count;
                TMR_STATUS: bus.rdata <= {{(WB_DW-1){1'b0}}, status_q};
                default:    bus.rdata <= '0;
            endcase
        end
    end

    interval_timer #(
        .PRESCALE_W (PRESCALE_W)
    ) u_interval_timer (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .enable_i   (ctrl_q[CTRL_EN_BIT]),
        .mode_i     (mode),
        .load_i     (load_val),
        .load_now_i (load_now),
        .count_o    (count),
        .match_o    (match),
        .done_o     (done)
    );

endmodule

// File: source/user_wrapper.sv
// Top level of the user area: address decode, two slave FSMs,
// debug scratch registers and interval timer bank
module user_wrapper import wb_pkg::*; #(
    parameter int unsigned PRESCALE_W = 4
) (
    input  logic             wb_clk_i,
    input  logic             reset_i,
    input  logic             wbs_stb_i,
    input  logic             wbs_cyc_i,
    input  logic             wbs_we_i,
    input  logic [WB_SW-1:0] wbs_sel_i,
    input  logic [WB_DW-1:0] wbs_dat_i,
    input  logic [WB_AW-1:0] wbs_adr_i,
    output logic             wbs_ack_o,
    output logic [WB_DW-1:0] wbs_dat_o,
    output logic             user_irq_o
);

    logic             cyc_user;
    logic             cyc_debug;
    logic             ack_user;
    logic             ack_debug;
    logic [WB_DW-1:0] dat_user;
    logic [WB_DW-1:0] dat_debug;

    reg_bus_if user_bus ();
    reg_bus_if debug_bus ();

    wb_decode u_decode (
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_adr_i   (wbs_adr_i),
        .ack_user_i  (ack_user),
        .ack_debug_i (ack_debug),
        .dat_user_i  (dat_user),
        .dat_debug_i (dat_debug),
        .cyc_user_o  (cyc_user),
        .cyc_debug_o (cyc_debug),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o)
    );

    // Timer region
    wb_slave_fsm u_fsm_user (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .wbs_cyc_i (cyc_user),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (ack_user),
        .wbs_dat_o (dat_user),
        .bus       (user_bus.master)
    );

    // Debug region, last two words of the address space
    wb_slave_fsm u_fsm_debug (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .wbs_cyc_i (cyc_debug),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (ack_debug),
        .wbs_dat_o (dat_debug),
        .bus       (debug_bus.master)
    );

    debug_regs u_debug_regs (
        .wb_clk_i (wb_clk_i),
        .reset_i  (reset_i),
        .bus      (debug_bus.slave)
    );

    timer_regs #(
        .PRESCALE_W (PRESCALE_W)
    ) u_timer_regs (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .bus        (user_bus.slave),
        .user_irq_o (user_irq_o)
    );

endmodule

// File: tb/tb_user_wrapper.sv
// Directed testbench for the user area wrapper
// Bus tasks, check task, LCG and tests for debug registers and timer
module tb_user_wrapper;

    localparam int unsigned PRESCALE_W  = 2;
    localparam int          ACK_TIMEOUT = 20;
    localparam int          IRQ_TIMEOUT = 200;

    // Debug region is the top two words, timer region starts at zero
    localparam logic [31:0] DEBUG0_ADR = 32'h000F_FFF8;
    localparam logic [31:0] DEBUG1_ADR = 32'h000F_FFFC;
    localparam logic [31:0] CTRL_ADR   = 32'h0000_0000;
    localparam logic [31:0] LOAD_ADR   = 32'h0000_0004;
    localparam logic [31:0] COUNT_ADR  = 32'h0000_0008;
    localparam logic [31:0] STATUS_ADR = 32'h0000_000C;

    logic        wb_clk;
    logic        reset;
    logic        wbs_stb;
    logic        wbs_cyc;
    logic        wbs_we;
    logic [3:0]  wbs_sel;
    logic [31:0] wbs_dat_w;
    logic [31:0] wbs_adr;
    logic        wbs_ack;
    logic [31:0] wbs_dat_r;
    logic        user_irq;

    int          error_count;
    int          check_count;
    logic [31:0] lcg_state;
    // Expected contents of the two debug registers
    logic [31:0] debug_model [2];

    user_wrapper #(
        .PRESCALE_W (PRESCALE_W)
    ) user_wrapper_inst (
        .wb_clk_i   (wb_clk),
        .reset_i    (reset),
        .wbs_stb_i  (wbs_stb),
        .wbs_cyc_i  (wbs_cyc),
        .wbs_we_i   (wbs_we),
        .wbs_sel_i  (wbs_sel),
        .wbs_dat_i  (wbs_dat_w),
        .wbs_adr_i  (wbs_adr),
        .wbs_ack_o  (wbs_ack),
        .wbs_dat_o  (wbs_dat_r),
        .user_irq_o (user_irq)
    );

    always #2 wb_clk = ~wb_clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected word after a byte-lane write
    function automatic logic [31:0] apply_sel(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  sel
    );
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error at time %0t: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    // Outputs sampled and inputs driven 1 unit after the rising edge
    task automatic step_clock();
        @(posedge wb_clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step_clock();
    endtask

    // One classic cycle, ack expected in the second cycle after stb is sampled
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] data,
                             input logic [3:0] sel, output logic [31:0] rdata);
        int   waited;
        logic got_ack;
        wbs_cyc   = 1'b1;
        wbs_stb   = 1'b1;
        wbs_we    = we;
        wbs_adr   = adr;
        wbs_dat_w = data;
        wbs_sel   = sel;
        waited    = 0;
        got_ack   = 1'b0;
        rdata     = '0;
        while (!got_ack && waited < ACK_TIMEOUT) begin
            step_clock();
            waited++;
            got_ack = wbs_ack;
        end
        if (!got_ack) begin
            error_count++;
            $display("Timeout: no ack within %0d cycles for address %h at time %0t",
                     ACK_TIMEOUT, adr, $time);
        end else begin
            check_value("wbs_ack_o latency", 32'd2, waited);
            rdata = wbs_dat_r;
        end
        wbs_cyc = 1'b0;
        wbs_stb = 1'b0;
        wbs_we  = 1'b0;
        step_clock();
        // Ack must be a single-cycle pulse
        check_value("wbs_ack_o after ack", 32'd0, wbs_ack);
        step_clock();
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [31:0] data,
                            input logic [3:0] sel);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, sel, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'd0, 4'hF, data);
    endtask

    task automatic expect_read(input string name, input logic [31:0] adr,
                               input logic [31:0] expected);
        logic [31:0] data;
        wb_read(adr, data);
        check_value(name, expected, data);
    endtask

    task automatic wait_for_irq(input int limit, output bit seen);
        int waited;
        waited = 0;
        while (!user_irq && waited < limit) begin
            step_clock();
            waited++;
        end
        seen = user_irq;
        if (!seen) begin
            error_count++;
            $display("Timeout: user_irq_o did not rise within %0d cycles at time %0t",
                     limit, $time);
        end
    endtask

    task automatic check_reset_values();
        check_value("user_irq_o", 32'd0, user_irq);
        check_value("wbs_ack_o", 32'd0, wbs_ack);
        expect_read("debug reg 0", DEBUG0_ADR, 32'd0);
        expect_read("debug reg 1", DEBUG1_ADR, 32'd0);
        expect_read("CTRL", CTRL_ADR, 32'd0);
        expect_read("LOAD", LOAD_ADR, 32'd0);
        expect_read("COUNT", COUNT_ADR, 32'd0);
        expect_read("STATUS", STATUS_ADR, 32'd0);
    endtask

    task automatic exercise_debug_bytes();
        logic [31:0] r;
        logic [31:0] data;
        logic [3:0]  sel;
        int          idx;
        for (int i = 0; i < 16; i++) begin
            // Upper LCG bits, the low ones repeat quickly
            r    = next_random();
            idx  = r[31];
            sel  = r[27:24];
            data = next_random();
            wb_write(idx ? DEBUG1_ADR : DEBUG0_ADR, data, sel);
            debug_model[idx] = apply_sel(debug_model[idx], data, sel);
            expect_read(idx ? "debug reg 1" : "debug reg 0",
                        idx ? DEBUG1_ADR : DEBUG0_ADR, debug_model[idx]);
        end
        expect_read("debug reg 0", DEBUG0_ADR, debug_model[0]);
        expect_read("debug reg 1", DEBUG1_ADR, debug_model[1]);
    endtask

    task automatic interleave_regions();
        logic [31:0] data;
        logic [31:0] load_val;
        int          idx;
        for (int i = 0; i < 6; i++) begin
            idx      = i % 2;
            data     = next_random();
            load_val = next_random();
            wb_write(idx ? DEBUG1_ADR : DEBUG0_ADR, data, 4'hF);
            debug_model[idx] = data;
            wb_write(LOAD_ADR, load_val, 4'hF);
            expect_read("debug reg 0", DEBUG0_ADR, debug_model[0]);
            expect_read("debug reg 1", DEBUG1_ADR, debug_model[1]);
            expect_read("LOAD", LOAD_ADR, load_val);
            // Stopped timer takes LOAD into the counter
            expect_read("COUNT", COUNT_ADR, load_val);
        end
        expect_read("CTRL", CTRL_ADR, 32'd0);
    endtask

    task automatic run_oneshot_timer();
        bit          seen;
        logic [31:0] data;
        wb_write(LOAD_ADR, 32'd5, 4'hF);
        // Enable, one-shot, irq enable
        wb_write(CTRL_ADR, 32'h5, 4'hF);
        wait_for_irq(IRQ_TIMEOUT, seen);
        if (seen) begin
            expect_read("COUNT", COUNT_ADR, 32'd0);
            expect_read("STATUS", STATUS_ADR, 32'd1);
            wb_read(CTRL_ADR, data);
            check_value("CTRL enable bit", 32'd0, data[0]);
            idle_cycles(40);
            expect_read("COUNT", COUNT_ADR, 32'd0);
        end
        wb_write(STATUS_ADR, 32'd1, 4'hF);
        wb_write(CTRL_ADR, 32'd0, 4'hF);
        check_value("user_irq_o", 32'd0, user_irq);
    endtask

    task automatic run_periodic_timer();
        bit          seen;
        bit          rose;
        int          waited;
        logic [31:0] data;
        wb_write(LOAD_ADR, 32'd3, 4'hF);
        // Enable, periodic, irq enable
        wb_write(CTRL_ADR, 32'h7, 4'hF);
        wait_for_irq(IRQ_TIMEOUT, seen);
        wb_write(STATUS_ADR, 32'd1, 4'hF);
        waited = 0;
        while (user_irq && waited < 3) begin
            step_clock();
            waited++;
        end
        check_value("user_irq_o after status clear", 32'd0, user_irq);
        // Next period raises it again
        wait_for_irq(IRQ_TIMEOUT, seen);
        wb_read(COUNT_ADR, data);
        check_value("COUNT within 0 to 3", 32'd1, data <= 32'd3);
        // Irq enable off, timer keeps running
        wb_write(CTRL_ADR, 32'h3, 4'hF);
        wb_write(STATUS_ADR, 32'd1, 4'hF);
        rose = 1'b0;
        for (int i = 0; i < 100; i++) begin
            step_clock();
            if (user_irq) begin
                rose = 1'b1;
            end
        end
        check_value("user_irq_o with irq disabled", 32'd0, rose);
        expect_read("STATUS", STATUS_ADR, 32'd1);
        wb_write(CTRL_ADR, 32'd0, 4'hF);
    endtask

    initial begin
        wb_clk         = 1'b0;
        reset          = 1'b1;
        wbs_stb        = 1'b0;
        wbs_cyc        = 1'b0;
        wbs_we         = 1'b0;
        wbs_sel        = '0;
        wbs_dat_w      = '0;
        wbs_adr        = '0;
        error_count    = 0;
        check_count    = 0;
        lcg_state      = 32'h68ec;
        debug_model[0] = '0;
        debug_model[1] = '0;

        repeat (3) @(posedge wb_clk);
        #1;
        reset = 1'b0;
        step_clock();

        check_reset_values();
        exercise_debug_bytes();
        interleave_regions();
        run_oneshot_timer();
        run_periodic_timer();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: user_wrapper.f
common/wb_pkg.sv
common/timer_pkg.sv
common/reg_bus_if.sv
source/wb_decode.sv
source/wb_slave_fsm.sv
source/debug_regs.sv
timer/interval_timer.sv
timer/timer_regs.sv
source/user_wrapper.sv
tb/tb_user_wrapper.sv

// File: Bender.yml
package:
  name: user_wrapper

sources:
  - common/wb_pkg.sv
  - common/timer_pkg.sv
  - common/reg_bus_if.sv
  - source/wb_decode.sv
  - source/wb_slave_fsm.sv
  - source/debug_regs.sv
  - timer/interval_timer.sv
  - timer/timer_regs.sv
  - source/user_wrapper.sv
  - target: simulation
    files:
      - tb/tb_user_wrapper.sv
